//--- source/csr_pkg.sv
`default_nettype none

package csr_pkg;

   // widths with a meaning of their own
   typedef logic [31:0] xlen_t;
   typedef logic [11:0] csr_addr_t;
   typedef logic [31:2] pc_word_t;   // pc without the byte offset
   typedef logic [1:0]  exc_t;

   typedef enum logic [1:0] {
      OP_NONE = 2'b00,
      OP_RW   = 2'b01,
      OP_RS   = 2'b10,
      OP_RC   = 2'b11
   } csr_op_e;

   // execute-stage exception codes
   localparam exc_t EXC_NONE    = 2'b00;
   localparam exc_t EXC_ILLEGAL = 2'b01;
   localparam exc_t EXC_ECALL   = 2'b10;
   localparam exc_t EXC_BREAK   = 2'b11;

   localparam xlen_t CAUSE_ILLEGAL = 32'd2;
   localparam xlen_t CAUSE_ECALL   = 32'd11;   // ecall from m-mode
   localparam xlen_t CAUSE_BREAK   = 32'd3;

   localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
   localparam csr_addr_t ADDR_MISA     = 12'h301;
   localparam csr_addr_t ADDR_MTVEC    = 12'h305;
   localparam csr_addr_t ADDR_MSTATUSH = 12'h310;
   localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
   localparam csr_addr_t ADDR_MEPC     = 12'h341;
   localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
   localparam csr_addr_t ADDR_MTVAL    = 12'h343;

   // A, B, F and M
   localparam xlen_t MISA_EXT_MASK = 32'h0000_1023;

   typedef struct packed {
      xlen_t set;
      xlen_t clear;
   } csr_wr_t;

   typedef struct packed {
      logic mstatus;
      logic misa;
      logic mtvec;
      logic mscratch;
      logic mepc;
      logic mcause;
      logic mstatush;
      logic mtval;
   } csr_sel_t;

   typedef csr_sel_t csr_ack_t;   // same layout, driven by the banks

   typedef struct packed {
      logic     valid;
      exc_t     code;
      pc_word_t pc;
   } trap_t;

endpackage

`default_nettype wire

//--- source/csr_op_decode.sv
`timescale 1ns/10ps
`default_nettype none

module csr_op_decode (
   input  wire csr_pkg::csr_op_e   op_i,
   input  wire                     source_sel_i,   // 0 = rs1, 1 = uimm
   input  wire [4:0]               rs1_label_i,
   input  wire csr_pkg::xlen_t     rs1_value_i,
   input  wire                     en_i,
   input  wire csr_pkg::csr_addr_t addr_i,

   output csr_pkg::csr_wr_t        wr_o,
   output csr_pkg::csr_sel_t       sel_o
);

   import csr_pkg::*;

   xlen_t source;

   assign source = source_sel_i ? {27'd0, rs1_label_i} : rs1_value_i;

   // set and clear masks for the register banks
   always_comb begin
      wr_o = '0;
      case (op_i)
         OP_RW: begin
            wr_o.set   = source;
            wr_o.clear = ~source;
         end
         OP_RS: begin
            wr_o.set = source;
         end
         OP_RC: begin
            wr_o.clear = source;
         end
         default: begin
            wr_o = '0;   // OP_NONE, read only
         end
      endcase
   end

   // one compare per register
   always_comb begin
      sel_o          = '0;
      sel_o.mstatus  = en_i && (addr_i == ADDR_MSTATUS);
      sel_o.misa     = en_i && (addr_i == ADDR_MISA);
      sel_o.mtvec    = en_i && (addr_i == ADDR_MTVEC);
      sel_o.mscratch = en_i && (addr_i == ADDR_MSCRATCH);
      sel_o.mepc     = en_i && (addr_i == ADDR_MEPC);
      sel_o.mcause   = en_i && (addr_i == ADDR_MCAUSE);
      sel_o.mstatush = en_i && (addr_i == ADDR_MSTATUSH);
      sel_o.mtval    = en_i && (addr_i == ADDR_MTVAL);
   end

   // catches two registers mapped to the same address
   a_sel_onehot0: assert final ($onehot0(sel_o))
      else $error("csr_op_decode: more than one select for addr %h", addr_i);

endmodule

`default_nettype wire

//--- source/csr_trap_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_trap_regs #(
   parameter csr_pkg::xlen_t MTVEC_RESET = 32'h0000_0000
) (
   input  wire                   clk_i,
   input  wire                   rst_n_i,

   input  wire csr_pkg::csr_wr_t  wr_i,
   input  wire csr_pkg::csr_sel_t sel_i,
   input  wire csr_pkg::trap_t    trap_i,

   output csr_pkg::csr_ack_t      ack_o,
   output csr_pkg::xlen_t         mtvec_o,
   output csr_pkg::xlen_t         mepc_o,
   output csr_pkg::xlen_t         mcause_o
);

   import csr_pkg::*;

   pc_word_t mtvec_q;   // direct mode only
   pc_word_t mepc_q;
   xlen_t    mcause_q;

   xlen_t mtvec_wr;
   xlen_t mepc_wr;
   xlen_t mcause_wr;
   xlen_t trap_cause;

   assign mtvec_o  = {mtvec_q, 2'b00};
   assign mepc_o   = {mepc_q, 2'b00};
   assign mcause_o = mcause_q;

   assign mtvec_wr  = (mtvec_o & ~wr_i.clear) | wr_i.set;
   assign mepc_wr   = (mepc_o & ~wr_i.clear) | wr_i.set;
   assign mcause_wr = (mcause_o & ~wr_i.clear) | wr_i.set;

   always_comb begin
      case (trap_i.code)
         EXC_ILLEGAL: trap_cause = CAUSE_ILLEGAL;
         EXC_ECALL:   trap_cause = CAUSE_ECALL;
         EXC_BREAK:   trap_cause = CAUSE_BREAK;
         default:     trap_cause = '0;
      endcase
   end

   always_comb begin
      ack_o        = '0;
      ack_o.mtvec  = sel_i.mtvec;
      ack_o.mepc   = sel_i.mepc;
      ack_o.mcause = sel_i.mcause;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mtvec_q  <= MTVEC_RESET[31:2];
         mepc_q   <= '0;
         mcause_q <= '0;
      end else begin
         if (sel_i.mtvec) begin
            mtvec_q <= mtvec_wr[31:2];
         end
         if (trap_i.valid) begin   // trap beats a csr write
            mepc_q   <= trap_i.pc;
            mcause_q <= trap_cause;
         end else begin
            if (sel_i.mepc) begin
               mepc_q <= mepc_wr[31:2];
            end
            if (sel_i.mcause) begin
               mcause_q <= mcause_wr;
            end
         end
      end
   end

   // valid is formed upstream from ex_en and a nonzero code
   a_trap_code: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      trap_i.valid |-> (trap_i.code != EXC_NONE))
      else $error("csr_trap_regs: valid trap without exception code");

endmodule

`default_nettype wire

//--- source/csr_status_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_status_regs #(
   parameter csr_pkg::xlen_t MISA_EXT_RESET = 32'h0000_0000
) (
   input  wire                    clk_i,
   input  wire                    rst_n_i,

   input  wire csr_pkg::csr_wr_t  wr_i,
   input  wire csr_pkg::csr_sel_t sel_i,
   input  wire csr_pkg::trap_t    trap_i,

   output csr_pkg::csr_ack_t      ack_o,
   output csr_pkg::xlen_t         mstatus_o,
   output csr_pkg::xlen_t         misa_o,
   output csr_pkg::xlen_t         mscratch_o,

   output logic                   is_a_supported_o,
   output logic                   is_b_supported_o,
   output logic                   is_f_supported_o,
   output logic                   is_m_supported_o
);

   import csr_pkg::*;

   localparam int MIE_BIT  = 3;
   localparam int MPIE_BIT = 7;
   localparam int EXT_A    = 0;
   localparam int EXT_B    = 1;
   localparam int EXT_F    = 5;
   localparam int EXT_M    = 12;

   localparam xlen_t MSTATUS_MPP = 32'h0000_1800;   // mpp fixed at 11
   localparam xlen_t MISA_MXL    = 32'h4000_0000;   // mxl = 01, 32 bit

   logic  mie_q;
   logic  mpie_q;
   xlen_t misa_ext_q;
   xlen_t mscratch_q;

   xlen_t mstatus_wr;
   xlen_t misa_wr;
   xlen_t mscratch_wr;

   always_comb begin
      mstatus_o           = MSTATUS_MPP;
      mstatus_o[MIE_BIT]  = mie_q;
      mstatus_o[MPIE_BIT] = mpie_q;
   end

   assign misa_o     = MISA_MXL | misa_ext_q;
   assign mscratch_o = mscratch_q;

   assign mstatus_wr  = (mstatus_o & ~wr_i.clear) | wr_i.set;
   assign misa_wr     = (misa_o & ~wr_i.clear) | wr_i.set;
   assign mscratch_wr = (mscratch_o & ~wr_i.clear) | wr_i.set;

   assign is_a_supported_o = misa_ext_q[EXT_A];
   assign is_b_supported_o = misa_ext_q[EXT_B];
   assign is_f_supported_o = misa_ext_q[EXT_F];
   assign is_m_supported_o = misa_ext_q[EXT_M];

   // mstatush and mtval have no storage, only an ack
   always_comb begin
      ack_o          = '0;
      ack_o.mstatus  = sel_i.mstatus;
      ack_o.misa     = sel_i.misa;
      ack_o.mscratch = sel_i.mscratch;
      ack_o.mstatush = sel_i.mstatush;
      ack_o.mtval    = sel_i.mtval;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mie_q      <= 1'b0;
         mpie_q     <= 1'b0;
         misa_ext_q <= MISA_EXT_RESET & MISA_EXT_MASK;
         mscratch_q <= '0;
      end else begin
         if (trap_i.valid) begin
            mpie_q <= mie_q;   // push mie
            mie_q  <= 1'b0;
         end else if (sel_i.mstatus) begin
            mie_q  <= mstatus_wr[MIE_BIT];
            mpie_q <= mstatus_wr[MPIE_BIT];
         end
         if (sel_i.misa) begin
            misa_ext_q <= misa_wr & MISA_EXT_MASK;
         end
         if (sel_i.mscratch) begin
            mscratch_q <= mscratch_wr;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/csr_read_merge.sv
`timescale 1ns/10ps
`default_nettype none

module csr_read_merge (
   input  wire                    en_i,
   input  wire csr_pkg::csr_ack_t ack_i,

   input  wire csr_pkg::xlen_t    mstatus_i,
   input  wire csr_pkg::xlen_t    misa_i,
   input  wire csr_pkg::xlen_t    mtvec_i,
   input  wire csr_pkg::xlen_t    mscratch_i,
   input  wire csr_pkg::xlen_t    mepc_i,
   input  wire csr_pkg::xlen_t    mcause_i,

   output csr_pkg::xlen_t         read_o,
   output logic                   illegal_o
);

   import csr_pkg::*;

   // unacked values drop out, zero registers contribute nothing
   assign read_o = ({32{ack_i.mstatus}}  & mstatus_i)
                 | ({32{ack_i.misa}}     & misa_i)
                 | ({32{ack_i.mtvec}}    & mtvec_i)
                 | ({32{ack_i.mscratch}} & mscratch_i)
                 | ({32{ack_i.mepc}}     & mepc_i)
                 | ({32{ack_i.mcause}}   & mcause_i);

   assign illegal_o = en_i && (ack_i == '0);

   // acks come from two banks; no access may be claimed twice
   a_ack_on: assert final (!en_i || $onehot0(ack_i))
      else $error("csr_read_merge: %0d acks for one access", $countones(ack_i));

   a_ack_off: assert final (en_i || (ack_i == '0))
      else $error("csr_read_merge: ack without en_i");

endmodule

`default_nettype wire

//--- source/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit #(
   parameter csr_pkg::xlen_t MTVEC_RESET    = 32'h0000_0100,
   parameter csr_pkg::xlen_t MISA_EXT_RESET = 32'h0000_1001
) (
   input  wire                     clk_i,
   input  wire                     rst_n_i,

   input  wire                     ex_en_i,
   input  wire csr_pkg::exc_t      exception_i,

   input  wire                     en_i,
   input  wire csr_pkg::csr_op_e   op_i,
   input  wire                     source_sel_i,
   input  wire [4:0]               rs1_label_i,
   input  wire csr_pkg::xlen_t     rs1_value_i,
   input  wire csr_pkg::csr_addr_t addr_i,
   input  wire csr_pkg::pc_word_t  pc_i,

   output csr_pkg::xlen_t          read_o,
   output csr_pkg::xlen_t          mtvec_o,
   output csr_pkg::xlen_t          mepc_o,

   output logic                    is_a_supported_o,
   output logic                    is_b_supported_o,
   output logic                    is_f_supported_o,
   output logic                    is_m_supported_o,

   output logic                    illegal_o
);

   import csr_pkg::*;

   csr_wr_t  wr;
   csr_sel_t sel;
   trap_t    trap;
   csr_ack_t trap_ack;
   csr_ack_t status_ack;
   csr_ack_t ack;

   xlen_t mcause;
   xlen_t mstatus;
   xlen_t misa;
   xlen_t mscratch;

   always_comb begin
      trap.valid = ex_en_i && (exception_i != EXC_NONE);
      trap.code  = exception_i;
      trap.pc    = pc_i;
   end

   assign ack = trap_ack | status_ack;   // banks own disjoint fields

   csr_op_decode u_decode (
      .op_i         (op_i),
      .source_sel_i (source_sel_i),
      .rs1_label_i  (rs1_label_i),
      .rs1_value_i  (rs1_value_i),
      .en_i         (en_i),
      .addr_i       (addr_i),
      .wr_o         (wr),
      .sel_o        (sel)
   );

   csr_trap_regs #(
      .MTVEC_RESET (MTVEC_RESET)
   ) u_trap_regs (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_i     (wr),
      .sel_i    (sel),
      .trap_i   (trap),
      .ack_o    (trap_ack),
      .mtvec_o  (mtvec_o),
      .mepc_o   (mepc_o),
      .mcause_o (mcause)
   );

   csr_status_regs #(
      .MISA_EXT_RESET (MISA_EXT_RESET)
   ) u_status_regs (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .wr_i             (wr),
      .sel_i            (sel),
      .trap_i           (trap),
      .ack_o            (status_ack),
      .mstatus_o        (mstatus),
      .misa_o           (misa),
      .mscratch_o       (mscratch),
      .is_a_supported_o (is_a_supported_o),
      .is_b_supported_o (is_b_supported_o),
      .is_f_supported_o (is_f_supported_o),
      .is_m_supported_o (is_m_supported_o)
   );

   csr_read_merge u_read_merge (
      .en_i       (en_i),
      .ack_i      (ack),
      .mstatus_i  (mstatus),
      .misa_i     (misa),
      .mtvec_i    (mtvec_o),
      .mscratch_i (mscratch),
      .mepc_i     (mepc_o),
      .mcause_i   (mcause),
      .read_o     (read_o),
      .illegal_o  (illegal_o)
   );

endmodule

`default_nettype wire

//--- tests/csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_tb;

   import csr_pkg::*;

   localparam time CLK_PERIOD    = 40ns;
   localparam int  RESET_CYCLES  = 5;
   localparam int  RESET_TIMEOUT = 20;
   localparam int  MAX_CYCLES    = 400;

   logic      clk_i;
   logic      rst_n_i;
   logic      ex_en_i;
   exc_t      exception_i;
   logic      en_i;
   csr_op_e   op_i;
   logic      source_sel_i;
   logic [4:0] rs1_label_i;
   xlen_t     rs1_value_i;
   csr_addr_t addr_i;
   pc_word_t  pc_i;

   xlen_t read_o;
   xlen_t mtvec_o;
   xlen_t mepc_o;
   logic  is_a_supported_o;
   logic  is_b_supported_o;
   logic  is_f_supported_o;
   logic  is_m_supported_o;
   logic  illegal_o;

   csr_unit #(
      .MTVEC_RESET    (32'h0000_0203),   // low bits must drop
      .MISA_EXT_RESET (32'h0000_1001)    // A and M
   ) csr_unit_i (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .ex_en_i          (ex_en_i),
      .exception_i      (exception_i),
      .en_i             (en_i),
      .op_i             (op_i),
      .source_sel_i     (source_sel_i),
      .rs1_label_i      (rs1_label_i),
      .rs1_value_i      (rs1_value_i),
      .addr_i           (addr_i),
      .pc_i             (pc_i),
      .read_o           (read_o),
      .mtvec_o          (mtvec_o),
      .mepc_o           (mepc_o),
      .is_a_supported_o (is_a_supported_o),
      .is_b_supported_o (is_b_supported_o),
      .is_f_supported_o (is_f_supported_o),
      .is_m_supported_o (is_m_supported_o),
      .illegal_o        (illegal_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      rst_n_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_n_i <= 1'b1;
   end

   // watchdog for the whole run
   initial begin
      repeat (MAX_CYCLES) @(posedge clk_i);
      $display("run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
   end

   task automatic compare_output(input string test, input string what,
                                 input xlen_t expected, input xlen_t actual);
      assert (actual === expected)
         else begin
            $display("FAILED %s %s expected %h actual %h", test, what, expected, actual);
            $display("Simulation failed");
            $fatal(1);
         end
   endtask

   initial begin
      int    fd;
      int    fields;
      int    wait_cnt;
      int    n_vectors;
      string line;
      string name;
      logic [31:0] v_en, v_op, v_src, v_imm, v_rs1, v_addr, v_ex_en, v_exc, v_pc;
      logic [31:0] v_read, v_ill, v_mtvec, v_mepc, v_sup, v_mask;

      ex_en_i      = 1'b0;
      exception_i  = EXC_NONE;
      en_i         = 1'b0;
      op_i         = OP_NONE;
      source_sel_i = 1'b0;
      rs1_label_i  = '0;
      rs1_value_i  = '0;
      addr_i       = '0;
      pc_i         = '0;
      n_vectors    = 0;

      wait_cnt = 0;
      while (rst_n_i !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
         @(posedge clk_i);
         wait_cnt++;
      end
      if (rst_n_i !== 1'b1) begin
         $display("reset was not released within %0d cycles", RESET_TIMEOUT);
         $display("Simulation failed");
         $fatal(1);
      end

      fd = $fopen("tests/csr_unit_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open the vector file tests/csr_unit_tests.txt");
         $display("Simulation failed");
         $fatal(1);
      end

      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line[0] == "#") continue;
         fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          name, v_en, v_op, v_src, v_imm, v_rs1, v_addr, v_ex_en, v_exc,
                          v_pc, v_read, v_ill, v_mtvec, v_mepc, v_sup, v_mask);
         if (fields != 16) begin
            $display("vector line could not be parsed: %s", line);
            $display("Simulation failed");
            $fatal(1);
         end

         @(posedge clk_i);
         en_i         <= v_en[0];
         op_i         <= csr_op_e'(v_op[1:0]);
         source_sel_i <= v_src[0];
         rs1_label_i  <= v_imm[4:0];
         rs1_value_i  <= v_rs1;
         addr_i       <= v_addr[11:0];
         ex_en_i      <= v_ex_en[0];
         exception_i  <= v_exc[1:0];
         pc_i         <= v_pc[31:2];   // file holds byte address

         #(CLK_PERIOD - 5ns);   // just before the next edge
         if (v_mask[0]) compare_output(name, "read_o", v_read, read_o);
         if (v_mask[1]) compare_output(name, "illegal_o", v_ill, {31'd0, illegal_o});
         if (v_mask[2]) compare_output(name, "mtvec_o", v_mtvec, mtvec_o);
         if (v_mask[3]) compare_output(name, "mepc_o", v_mepc, mepc_o);
         if (v_mask[4]) compare_output(name, "support", v_sup,
                                       {28'd0, is_m_supported_o, is_f_supported_o,
                                        is_b_supported_o, is_a_supported_o});
         n_vectors++;
      end
      $fclose(fd);

      if (n_vectors > 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("no vectors found in tests/csr_unit_tests.txt");
         $display("Simulation failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

//--- tests/csr_unit_tests.txt
# name en op src imm rs1_value addr ex_en exc pc | read illegal mtvec mepc support mask
# hex values; pc is a byte address; support is {m,f,b,a}; mask bits read,illegal,mtvec,mepc,support
rst_mstatus      1 0 0 00 00000000 300 0 0 00000000 00001800 0 00000200 00000000 9 1f
rst_misa         1 0 0 00 00000000 301 0 0 00000000 40001001 0 00000200 00000000 9 1f
rst_mtvec        1 0 0 00 00000000 305 0 0 00000000 00000200 0 00000200 00000000 9 1f
rst_mepc         1 0 0 00 00000000 341 0 0 00000000 00000000 0 00000200 00000000 9 1f
rst_mcause       1 0 0 00 00000000 342 0 0 00000000 00000000 0 00000200 00000000 9 1f
rst_mstatush     1 0 0 00 00000000 310 0 0 00000000 00000000 0 00000200 00000000 9 1f
rst_mtval        1 0 0 00 00000000 343 0 0 00000000 00000000 0 00000200 00000000 9 1f
rw_mscratch      1 1 0 00 deadbeef 340 0 0 00000000 00000000 0 00000200 00000000 9 1f
rw_mtvec         1 1 0 00 00001237 305 0 0 00000000 00000200 0 00000200 00000000 9 1f
rs_mscratch_reg  1 2 0 00 000000f0 340 0 0 00000000 deadbeef 0 00001234 00000000 9 1f
rc_mscratch_imm  1 3 1 0f 00000000 340 0 0 00000000 deadbeff 0 00001234 00000000 9 1f
rs_mscratch_imm  1 2 1 05 00000000 340 0 0 00000000 deadbef0 0 00001234 00000000 9 1f
rc_mscratch_reg  1 3 0 00 ffff0000 340 0 0 00000000 deadbef5 0 00001234 00000000 9 1f
rd_mscratch      1 0 0 00 00000000 340 0 0 00000000 0000bef5 0 00001234 00000000 9 1f
rs_mstatus_all   1 2 0 00 ffffffff 300 0 0 00000000 00001800 0 00001234 00000000 9 1f
rc_mstatus_reg   1 3 0 00 00001808 300 0 0 00000000 00001888 0 00001234 00000000 9 1f
rw_misa          1 1 0 00 00000022 301 0 0 00000000 40001001 0 00001234 00000000 9 1f
rs_misa_mxl      1 2 0 00 c0001000 301 0 0 00000000 40000022 0 00001234 00000000 6 1f
rc_misa_imm      1 3 1 02 00000000 301 0 0 00000000 40001022 0 00001234 00000000 e 1f
rs_mie           1 2 1 08 00000000 300 0 0 00000000 00001880 0 00001234 00000000 c 1f
trap_ecall       0 0 0 00 00000000 000 1 2 00000104 00000000 0 00001234 00000000 c 1f
trap_vs_mepc     1 1 0 00 00000abc 341 1 3 00000208 00000104 0 00001234 00000104 c 1f
trap_vs_mstatus  1 1 0 00 00000088 300 1 1 00000300 00001800 0 00001234 00000208 c 1f
rd_mcause        1 0 0 00 00000000 342 0 0 00000000 00000002 0 00001234 00000300 c 1f
exc_disabled     0 0 0 00 00000000 000 0 3 00000500 00000000 0 00001234 00000300 c 1f
wr_mepc          1 1 0 00 00000123 341 0 0 00000000 00000300 0 00001234 00000300 c 1f
rw_mcause        1 1 0 00 8000000f 342 0 0 00000000 00000002 0 00001234 00000120 c 1f
rd_mcause_new    1 0 0 00 00000000 342 0 0 00000000 8000000f 0 00001234 00000120 c 1f
illegal_addr     1 1 0 00 ffffffff 7c0 0 0 00000000 00000000 1 00001234 00000120 c 1f
idle             0 0 0 00 00000000 7c0 0 0 00000000 00000000 0 00001234 00000120 c 1f

//--- csr_unit.f
source/csr_pkg.sv
source/csr_op_decode.sv
source/csr_trap_regs.sv
source/csr_status_regs.sv
source/csr_read_merge.sv
source/csr_unit.sv
tests/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - source/csr_pkg.sv
  - source/csr_op_decode.sv
  - source/csr_trap_regs.sv
  - source/csr_status_regs.sv
  - source/csr_read_merge.sv
  - source/csr_unit.sv
  - target: test
    files:
      - tests/csr_unit_tb.sv
